// ==== compile.f ====
logic/decode_pkg.sv
logic/inst_decoder.sv
logic/rename_table.sv
logic/phys_regfile.sv
logic/decode_issue_unit.sv
testbench/decode_issue_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       := decode_issue_tb
FILELIST  := compile.f
BUILD     := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -q "Errors found" $(LOG); then echo "FAIL"; exit 1; fi
	@if ! grep -q "No errors" $(LOG); then echo "FAIL"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf $(BUILD) $(LOG)

// ==== testbench/decode_issue_tb.sv ====
// Decode and issue testbench
// Acts as fetch, execute and commit around the decode and issue unit, walks
// a table of instructions and checks every issued bundle against a shadow
// rename model

`default_nettype none

module decode_issue_tb
  import decode_pkg::*;
();

  localparam int PHYS_REGS    = 36;
  localparam int PREG_W       = $clog2(PHYS_REGS);
  localparam int N_TESTS      = 11;
  localparam int MAX_CYCLES   = 40 * N_TESTS;
  localparam int STALL_CYCLES = 3;

  typedef logic [PREG_W-1:0] preg_t;

  // Actions before the issue
  localparam logic [1:0] PRE_NONE = 2'd0;
  localparam logic [1:0] PRE_CPL  = 2'd1;
  localparam logic [1:0] PRE_CMT  = 2'd2;

  typedef struct packed {
    logic [7:0] id;
    word_t      inst;
    word_t      pc;
    seq_t       seq;
    logic [3:0] delay;
    logic [1:0] pre;
    areg_t      cpl_areg;
    logic       post_cpl;
    uop_e       uop;
    word_t      imm;
    logic       sq;
  } row_t;

  // ----------------------------------------------------------------------
  // Test table
  // ----------------------------------------------------------------------

  // id, inst, pc, seq, x_rdy delay, pre action, areg to complete,
  // complete own preg after issue, uop, immediate, squash expected
  localparam row_t TESTS [N_TESTS] = '{
    '{8'd1,  32'h0050_0093, 32'h100, 8'd1,  4'd0, PRE_NONE, 5'd0, 1'b1, uop_addi, 32'h5, 1'b0},
    '{8'd2,  32'hffd0_8113, 32'h104, 8'd2,  4'd1, PRE_NONE, 5'd0, 1'b1, uop_addi,
      32'hffff_fffd, 1'b0},
    '{8'd3,  32'h0070_8013, 32'h108, 8'd3,  4'd0, PRE_NONE, 5'd0, 1'b0, uop_addi, 32'h7, 1'b0},
    '{8'd4,  32'h0220_81b3, 32'h10c, 8'd4,  4'd0, PRE_NONE, 5'd0, 1'b0, uop_mul,  32'h0, 1'b0},
    '{8'd5,  32'h0011_8233, 32'h110, 8'd5,  4'd0, PRE_CPL,  5'd3, 1'b1, uop_add,  32'h0, 1'b0},
    '{8'd6,  32'hfe41_2c23, 32'h114, 8'd6,  4'd2, PRE_NONE, 5'd0, 1'b0, uop_sw,
      32'hffff_fff8, 1'b0},
    '{8'd7,  32'h0010_8293, 32'h118, 8'd7,  4'd0, PRE_CMT,  5'd0, 1'b1, uop_addi, 32'h1, 1'b0},
    '{8'd8,  32'h0200_006f, 32'h11c, 8'd8,  4'd2, PRE_NONE, 5'd0, 1'b0, uop_jal,  32'h20, 1'b1},
    '{8'd9,  32'h0051_0067, 32'h140, 8'd9,  4'd1, PRE_NONE, 5'd0, 1'b0, uop_jalr, 32'h5, 1'b1},
    '{8'd10, 32'h0102_a383, 32'h144, 8'd10, 4'd5, PRE_CMT,  5'd0, 1'b1, uop_lw,   32'h10, 1'b0},
    '{8'd11, 32'h0043_8433, 32'h148, 8'd11, 4'd0, PRE_CMT,  5'd0, 1'b0, uop_add,  32'h0, 1'b0}
  };

  logic          clk;
  logic          rst;
  logic          f_val;
  logic          f_rdy;
  fetch_bundle_t f_inst;
  logic          x_val;
  logic          x_rdy;
  word_t         x_pc;
  word_t         x_op1;
  word_t         x_op2;
  word_t         x_op3;
  uop_e          x_uop;
  areg_t         x_waddr;
  seq_t          x_seq;
  preg_t         x_preg;
  preg_t         x_ppreg;
  logic          cpl_val;
  logic          cpl_wen;
  preg_t         cpl_preg;
  word_t         cpl_wdata;
  logic          cmt_val;
  preg_t         cmt_ppreg;
  logic          sq_val;
  word_t         sq_target;
  seq_t          sq_seq;

  int            errors;
  int            checks;
  logic [31:0]   rng;

  // Shadow rename state
  preg_t         shadow_map [32];
  word_t         shadow_val [PHYS_REGS];
  preg_t         free_q [$];
  preg_t         commit_q [$];

  decode_issue_unit #(
    .PHYS_REGS (PHYS_REGS)
  ) i_decode_issue_unit (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ----------------------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------------------

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic compare_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      $display("error: %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  // Held instruction neither issues nor lets fetch in
  task automatic expect_stall(input int n);
    repeat (n) begin
      @(negedge clk);
      compare_word("x_val", 32'(x_val), 32'd0);
      compare_word("f_rdy", 32'(f_rdy), 32'd0);
    end
  endtask

  // One-cycle completion with fresh data
  task automatic complete_reg(input preg_t preg);
    word_t data;
    rng  = xorshift32(rng);
    data = rng;
    @(posedge clk);
    cpl_val   <= 1'b1;
    cpl_wen   <= 1'b1;
    cpl_preg  <= preg;
    cpl_wdata <= data;
    @(posedge clk);
    cpl_val   <= 1'b0;
    cpl_wen   <= 1'b0;
    shadow_val[preg] = data;
  endtask

  // Oldest ppreg goes back to the free list
  task automatic commit_oldest();
    preg_t ppreg;
    ppreg = commit_q.pop_front();
    @(posedge clk);
    cmt_val   <= 1'b1;
    cmt_ppreg <= ppreg;
    @(posedge clk);
    cmt_val   <= 1'b0;
    free_q.push_back(ppreg);
  endtask

  task automatic send_fetch(input row_t r);
    @(posedge clk);
    f_val  <= 1'b1;
    f_inst <= '{inst: r.inst, pc: r.pc, seq: r.seq};
    // Transfer at the edge after f_rdy is seen high
    @(negedge clk);
    while (!f_rdy) @(negedge clk);
    @(posedge clk);
    f_val <= 1'b0;
  endtask

  // ----------------------------------------------------------------------
  // One table row from fetch to issue
  // ----------------------------------------------------------------------

  task automatic run_row(input row_t r);
    areg_t rd;
    areg_t rs1;
    areg_t rs2;
    logic  writes;
    preg_t exp_preg;
    preg_t exp_ppreg;
    word_t exp_op1;
    word_t exp_op2;
    word_t exp_op3;
    word_t exp_target;
    int    sq_count;
    int    c;
    int    errors_before;
    errors_before = errors;
    send_fetch(r);
    if (r.pre == PRE_CPL) begin
      expect_stall(STALL_CYCLES);
      complete_reg(shadow_map[r.cpl_areg]);
    end else if (r.pre == PRE_CMT) begin
      expect_stall(STALL_CYCLES);
      commit_oldest();
    end
    // Jal reads no source register
    rd         = r.inst[11:7];
    rs1        = (r.uop == uop_jal) ? 5'd0 : r.inst[19:15];
    rs2        = (r.uop inside {uop_add, uop_mul, uop_sw}) ? r.inst[24:20] : 5'd0;
    writes     = (r.uop != uop_sw) && (rd != 5'd0);
    exp_op1    = shadow_val[shadow_map[rs1]];
    exp_op3    = shadow_val[shadow_map[rs2]];
    exp_op2    = (r.uop inside {uop_add, uop_mul}) ? exp_op3 : r.imm;
    exp_preg   = writes ? free_q[0] : '0;
    exp_ppreg  = writes ? shadow_map[rd] : '0;
    exp_target = (r.uop == uop_jal) ? r.pc + r.imm : (exp_op1 + r.imm) & ~32'd1;
    // Wait for the offer
    @(negedge clk);
    while (!x_val) @(negedge clk);
    sq_count = 0;
    // x_rdy low for the delay, then one cycle high
    for (c = 0; c <= r.delay + 1; c++) begin
      if (c == r.delay + 1) begin
        @(posedge clk);
        x_rdy <= 1'b1;
        @(negedge clk);
      end else if (c > 0) begin
        @(negedge clk);
      end
      if (c > 0) begin
        compare_word("x_val", 32'(x_val), 32'd1);
      end
      compare_word("x_pc", x_pc, r.pc);
      compare_word("x_seq", 32'(x_seq), 32'(r.seq));
      compare_word("x_uop", 32'(x_uop), 32'(r.uop));
      compare_word("x_waddr", 32'(x_waddr), writes ? 32'(rd) : 32'd0);
      compare_word("x_op1", x_op1, exp_op1);
      compare_word("x_op2", x_op2, exp_op2);
      compare_word("x_op3", x_op3, exp_op3);
      compare_word("x_preg", 32'(x_preg), 32'(exp_preg));
      compare_word("x_ppreg", 32'(x_ppreg), 32'(exp_ppreg));
      if (c <= r.delay) begin
        compare_word("f_rdy", 32'(f_rdy), 32'd0);
      end else begin
        // Issuing this cycle frees the holding register
        compare_word("f_rdy", 32'(f_rdy), 32'd1);
      end
      if (sq_val) begin
        sq_count++;
        compare_word("sq_target", sq_target, exp_target);
        compare_word("sq_seq", 32'(sq_seq), 32'(r.seq));
      end
    end
    // Issue transfer at this edge
    @(posedge clk);
    x_rdy <= 1'b0;
    compare_word("sq_val pulses", 32'(sq_count), r.sq ? 32'd1 : 32'd0);
    if (writes) begin
      exp_preg     = free_q.pop_front();
      shadow_map[rd] = exp_preg;
      commit_q.push_back(exp_ppreg);
    end
    if (r.post_cpl) begin
      complete_reg(exp_preg);
    end
    if (errors == errors_before) begin
      $display("test %0d ok", r.id);
    end else begin
      $display("test %0d failed with %0d errors", r.id, errors - errors_before);
    end
  endtask

  // ----------------------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------------------

  initial begin
    int i;
    rst       = 1'b1;
    f_val     = 1'b0;
    f_inst    = '0;
    x_rdy     = 1'b0;
    cpl_val   = 1'b0;
    cpl_wen   = 1'b0;
    cpl_preg  = '0;
    cpl_wdata = '0;
    cmt_val   = 1'b0;
    cmt_ppreg = '0;
    errors    = 0;
    checks    = 0;
    rng       = 32'hda63_c743;
    for (i = 0; i < 32; i++) begin
      shadow_map[i] = preg_t'(i);
    end
    for (i = 0; i < PHYS_REGS; i++) begin
      shadow_val[i] = '0;
    end
    for (i = 32; i < PHYS_REGS; i++) begin
      free_q.push_back(preg_t'(i));
    end
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    // Idle state out of reset
    @(negedge clk);
    compare_word("x_val", 32'(x_val), 32'd0);
    compare_word("sq_val", 32'(sq_val), 32'd0);
    compare_word("f_rdy", 32'(f_rdy), 32'd1);
    for (i = 0; i < N_TESTS; i++) begin
      run_row(TESTS[i]);
    end
    $display("tests %0d, checks %0d, errors %0d", N_TESTS, checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  // Run limit
  initial begin
    int cycles;
    cycles = 0;
    while (cycles < MAX_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
    $display("Errors found");
    $finish;
  end

endmodule

`default_nettype wire

// ==== logic/decode_issue_unit.sv ====
// Decode and issue unit
// Holds one fetched instruction, decodes and renames it, reads operands,
// stalls on pending sources or an empty free list, and issues to execute;
// JAL and JALR raise a squash with the jump target

`default_nettype none

module decode_issue_unit
  import decode_pkg::*;
#(
  parameter  int PHYS_REGS = 36,
  localparam int PREG_W    = $clog2(PHYS_REGS)
) (
  input  logic              clk,
  input  logic              rst,
  // Fetch side
  input  logic              f_val,
  output logic              f_rdy,
  input  fetch_bundle_t     f_inst,
  // Execute side
  output logic              x_val,
  input  logic              x_rdy,
  output word_t             x_pc,
  output word_t             x_op1,
  output word_t             x_op2,
  output word_t             x_op3,
  output uop_e              x_uop,
  output areg_t             x_waddr,
  output seq_t              x_seq,
  output logic [PREG_W-1:0] x_preg,
  output logic [PREG_W-1:0] x_ppreg,
  // Completion
  input  logic              cpl_val,
  input  logic              cpl_wen,
  input  logic [PREG_W-1:0] cpl_preg,
  input  word_t             cpl_wdata,
  // Commit
  input  logic              cmt_val,
  input  logic [PREG_W-1:0] cmt_ppreg,
  // Squash
  output logic              sq_val,
  output word_t             sq_target,
  output seq_t              sq_seq
);

  typedef logic [PREG_W-1:0] preg_t;

  typedef struct packed {
    word_t pc;
    word_t op1;
    word_t op2;
    word_t op3;
    uop_e  uop;
    areg_t waddr;
    seq_t  seq;
    preg_t preg;
    preg_t ppreg;
  } issue_bundle_t;

  typedef struct packed {
    logic  val;
    logic  wen;
    preg_t preg;
    word_t wdata;
  } complete_t;

  fetch_bundle_t hold;
  logic          hold_val;
  logic          f_xfer;
  logic          x_xfer;
  complete_t     cpl;
  issue_bundle_t x_bundle;

  // ----------------------------------------------------------------------
  // Holding register for the fetched instruction
  // ----------------------------------------------------------------------

  assign f_xfer = f_val && f_rdy;
  assign x_xfer = x_val && x_rdy;
  // Empty, or emptying this cycle
  assign f_rdy  = !hold_val || x_xfer;

  always_ff @(posedge clk) begin
    if (rst) begin
      hold_val <= 1'b0;
    end else if (f_xfer) begin
      hold_val <= 1'b1;
    end else if (x_xfer) begin
      hold_val <= 1'b0;
    end
  end

  // Payload only
  always_ff @(posedge clk) begin
    if (f_xfer) begin
      hold <= f_inst;
    end
  end

  // ----------------------------------------------------------------------
  // Decode, rename and register read side by side
  // ----------------------------------------------------------------------

  uop_e  dec_uop;
  logic  dec_val;
  areg_t dec_raddr0;
  areg_t dec_raddr1;
  areg_t dec_waddr;
  logic  dec_wen;
  word_t dec_imm;
  logic  dec_op2_imm;
  logic  dec_jump;

  inst_decoder i_inst_decoder (
    .inst    (hold.inst),
    .uop     (dec_uop),
    .dec_val (dec_val),
    .raddr0  (dec_raddr0),
    .raddr1  (dec_raddr1),
    .waddr   (dec_waddr),
    .wen     (dec_wen),
    .imm     (dec_imm),
    .op2_imm (dec_op2_imm),
    .jump    (dec_jump)
  );

  assign cpl = '{val: cpl_val, wen: cpl_wen, preg: cpl_preg, wdata: cpl_wdata};

  logic  needs_alloc;
  logic  alloc_rdy;
  preg_t alloc_preg;
  preg_t alloc_ppreg;
  preg_t src_preg0;
  preg_t src_preg1;
  logic  src_pending0;
  logic  src_pending1;
  word_t rdata0;
  word_t rdata1;
  logic  stall;

  // Writes to x0 skip allocation
  assign needs_alloc = dec_wen && (dec_waddr != '0);

  rename_table #(
    .PHYS_REGS (PHYS_REGS)
  ) i_rename_table (
    .clk          (clk),
    .rst          (rst),
    .alloc_areg   (dec_waddr),
    .alloc_en     (x_xfer && needs_alloc),
    .alloc_rdy    (alloc_rdy),
    .alloc_preg   (alloc_preg),
    .alloc_ppreg  (alloc_ppreg),
    .src_areg0    (dec_raddr0),
    .src_areg1    (dec_raddr1),
    .src_preg0    (src_preg0),
    .src_preg1    (src_preg1),
    .src_pending0 (src_pending0),
    .src_pending1 (src_pending1),
    .cpl_val      (cpl.val),
    .cpl_wen      (cpl.wen),
    .cpl_preg     (cpl.preg),
    .cmt_val      (cmt_val),
    .cmt_ppreg    (cmt_ppreg)
  );

  phys_regfile #(
    .PHYS_REGS (PHYS_REGS)
  ) i_phys_regfile (
    .clk    (clk),
    .rst    (rst),
    .raddr0 (src_preg0),
    .raddr1 (src_preg1),
    .rdata0 (rdata0),
    .rdata1 (rdata1),
    .wen    (cpl.val && cpl.wen),
    .waddr  (cpl.preg),
    .wdata  (cpl.wdata)
  );

  // Wait on a busy source or an empty free list
  assign stall = src_pending0 || src_pending1 || (needs_alloc && !alloc_rdy);

  // ----------------------------------------------------------------------
  // Issue to execute
  // ----------------------------------------------------------------------

  assign x_val = hold_val && dec_val && !stall;

  always_comb begin
    x_bundle.pc    = hold.pc;
    x_bundle.op1   = rdata0;
    x_bundle.op2   = dec_op2_imm ? dec_imm : rdata1;
    // Store data
    x_bundle.op3   = rdata1;
    x_bundle.uop   = dec_uop;
    x_bundle.waddr = dec_waddr;
    x_bundle.seq   = hold.seq;
    x_bundle.preg  = alloc_preg;
    x_bundle.ppreg = alloc_ppreg;
  end

  assign x_pc    = x_bundle.pc;
  assign x_op1   = x_bundle.op1;
  assign x_op2   = x_bundle.op2;
  assign x_op3   = x_bundle.op3;
  assign x_uop   = x_bundle.uop;
  assign x_waddr = x_bundle.waddr;
  assign x_seq   = x_bundle.seq;
  assign x_preg  = x_bundle.preg;
  assign x_ppreg = x_bundle.ppreg;

  // ----------------------------------------------------------------------
  // Squash for jumps
  // ----------------------------------------------------------------------

  logic squash_sent;

  // One pulse per held jump, rearmed by the next fetch
  always_ff @(posedge clk) begin
    if (rst) begin
      squash_sent <= 1'b0;
    end else if (f_xfer) begin
      squash_sent <= 1'b0;
    end else if (sq_val) begin
      squash_sent <= 1'b1;
    end
  end

  assign sq_val    = hold_val && dec_jump && !stall && !squash_sent;
  // JALR clears bit 0 of the sum
  assign sq_target = (dec_uop == uop_jal) ? hold.pc + dec_imm
                                          : (rdata0 + dec_imm) & ~32'd1;
  assign sq_seq    = hold.seq;

  // Offer to execute holds until taken
  a_x_stable: assert property (@(posedge clk) disable iff (rst)
    (x_val && !x_rdy) |=> (x_val && $stable(x_bundle)));

endmodule

`default_nettype wire

// ==== logic/phys_regfile.sv ====
// Physical register file
// Two combinational read ports and one completion write port

`default_nettype none

module phys_regfile
  import decode_pkg::*;
#(
  parameter  int PHYS_REGS = 36,
  localparam int PREG_W    = $clog2(PHYS_REGS)
) (
  input  logic              clk,
  input  logic              rst,
  input  logic [PREG_W-1:0] raddr0,
  input  logic [PREG_W-1:0] raddr1,
  output word_t             rdata0,
  output word_t             rdata1,
  input  logic              wen,
  input  logic [PREG_W-1:0] waddr,
  input  word_t             wdata
);

  word_t regs [PHYS_REGS];

  // Read before write, no bypass
  assign rdata0 = regs[raddr0];
  assign rdata1 = regs[raddr1];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < PHYS_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && waddr != '0) begin
      // Register 0 stays zero
      regs[waddr] <= wdata;
    end
  end

  // Index must fall inside a non power of two array
  a_waddr_range: assert property (@(posedge clk) disable iff (rst)
    wen |-> int'(waddr) < PHYS_REGS);

endmodule

`default_nettype wire

// ==== logic/rename_table.sv ====
// Rename table
// Architectural-to-physical register map with a circular free list and
// per-register pending bits; allocation, completion and commit update it

`default_nettype none

module rename_table
  import decode_pkg::*;
#(
  parameter  int PHYS_REGS = 36,
  localparam int PREG_W    = $clog2(PHYS_REGS)
) (
  input  logic              clk,
  input  logic              rst,
  input  areg_t             alloc_areg,
  input  logic              alloc_en,
  output logic              alloc_rdy,
  output logic [PREG_W-1:0] alloc_preg,
  output logic [PREG_W-1:0] alloc_ppreg,
  input  areg_t             src_areg0,
  input  areg_t             src_areg1,
  output logic [PREG_W-1:0] src_preg0,
  output logic [PREG_W-1:0] src_preg1,
  output logic              src_pending0,
  output logic              src_pending1,
  input  logic              cpl_val,
  input  logic              cpl_wen,
  input  logic [PREG_W-1:0] cpl_preg,
  input  logic              cmt_val,
  input  logic [PREG_W-1:0] cmt_ppreg
);

  // Registers 32 and up start out free
  localparam int FREE_N = PHYS_REGS - 32;
  localparam int FIDX_W = (FREE_N > 1) ? $clog2(FREE_N) : 1;
  localparam int CNT_W  = $clog2(FREE_N + 1);

  typedef logic [PREG_W-1:0] preg_t;
  typedef logic [FIDX_W-1:0] fidx_t;
  typedef logic [CNT_W-1:0]  fcnt_t;

  preg_t                 map_tbl [32];
  preg_t                 free_list [FREE_N];
  fidx_t                 head;
  fidx_t                 tail;
  fcnt_t                 count;
  logic  [PHYS_REGS-1:0] pending;

  // ----------------------------------------------------------------------
  // Lookups from current state
  // ----------------------------------------------------------------------

  assign src_preg0    = map_tbl[src_areg0];
  assign src_preg1    = map_tbl[src_areg1];
  assign src_pending0 = pending[src_preg0];
  assign src_pending1 = pending[src_preg1];

  assign alloc_rdy    = (count != '0);
  // x0 never takes a register
  assign alloc_preg   = (alloc_areg == '0) ? '0 : free_list[head];
  assign alloc_ppreg  = map_tbl[alloc_areg];

  // ----------------------------------------------------------------------
  // State update
  // ----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        map_tbl[i] <= preg_t'(i);
      end
      for (int k = 0; k < FREE_N; k++) begin
        free_list[k] <= preg_t'(32 + k);
      end
      head    <= '0;
      tail    <= '0;
      count   <= fcnt_t'(FREE_N);
      pending <= '0;
    end else begin
      // Completion clears pending
      if (cpl_val && cpl_wen) begin
        pending[cpl_preg] <= 1'b0;
      end
      // Allocation pops the head and marks the new register busy
      if (alloc_en) begin
        map_tbl[alloc_areg]  <= alloc_preg;
        pending[alloc_preg]  <= 1'b1;
        head <= (head == fidx_t'(FREE_N - 1)) ? '0 : head + 1'b1;
      end
      // Commit pushes the old mapping on the tail
      if (cmt_val) begin
        free_list[tail] <= cmt_ppreg;
        tail <= (tail == fidx_t'(FREE_N - 1)) ? '0 : tail + 1'b1;
      end
      if (alloc_en && !cmt_val) begin
        count <= count - 1'b1;
      end else if (cmt_val && !alloc_en) begin
        count <= count + 1'b1;
      end
    end
  end

  // ----------------------------------------------------------------------
  // Checks
  // ----------------------------------------------------------------------

  // Issue must have held back a writer on an empty list
  a_alloc_nonempty: assert property (@(posedge clk) disable iff (rst)
    alloc_en |-> count != '0);

  // Commit can only return a register that was handed out
  a_commit_not_full: assert property (@(posedge clk) disable iff (rst)
    cmt_val |-> (count != fcnt_t'(FREE_N)) || alloc_en);

  // Execute never targets the zero register
  a_cpl_not_zero: assert property (@(posedge clk) disable iff (rst)
    (cpl_val && cpl_wen) |-> cpl_preg != '0);

endmodule

`default_nettype wire

// ==== logic/inst_decoder.sv ====
// Instruction decoder
// Maps a 32-bit RV32 instruction onto a micro-op, register addresses and a
// sign-extended immediate; anything outside the supported subset is invalid

`default_nettype none

module inst_decoder
  import decode_pkg::*;
(
  input  word_t inst,
  output uop_e  uop,
  output logic  dec_val,
  output areg_t raddr0,
  output areg_t raddr1,
  output areg_t waddr,
  output logic  wen,
  output word_t imm,
  output logic  op2_imm,
  output logic  jump
);

  // Instruction fields
  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  imm_e       imm_sel;

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];

  // ----------------------------------------------------------------------
  // Opcode and funct decode
  // ----------------------------------------------------------------------

  always_comb begin
    // Defaults read x0 so unused sources never stall
    uop     = uop_invalid;
    imm_sel = imm_none;
    raddr0  = '0;
    raddr1  = '0;
    wen     = 1'b0;
    op2_imm = 1'b0;
    case (opcode)
      OPC_OP: begin
        if (funct3 == F3_ADD && funct7 == F7_BASE) begin
          uop = uop_add;
        end else if (funct3 == F3_ADD && funct7 == F7_MULDIV) begin
          uop = uop_mul;
        end
        raddr0 = inst[19:15];
        raddr1 = inst[24:20];
        wen    = 1'b1;
      end
      OPC_OP_IMM, OPC_LOAD: begin
        if (opcode == OPC_OP_IMM && funct3 == F3_ADD) begin
          uop = uop_addi;
        end else if (opcode == OPC_LOAD && funct3 == F3_WORD) begin
          uop = uop_lw;
        end
        imm_sel = imm_i;
        raddr0  = inst[19:15];
        wen     = 1'b1;
        op2_imm = 1'b1;
      end
      OPC_STORE: begin
        if (funct3 == F3_WORD) begin
          uop = uop_sw;
        end
        imm_sel = imm_s;
        raddr0  = inst[19:15];
        // Store data comes through rs2
        raddr1  = inst[24:20];
        op2_imm = 1'b1;
      end
      OPC_JAL: begin
        uop     = uop_jal;
        imm_sel = imm_j;
        // Link value pc+4 is written in execute
        wen     = 1'b1;
        op2_imm = 1'b1;
      end
      OPC_JALR: begin
        if (funct3 == F3_ADD) begin
          uop = uop_jalr;
        end
        imm_sel = imm_i;
        raddr0  = inst[19:15];
        wen     = 1'b1;
        op2_imm = 1'b1;
      end
      default: begin
        uop = uop_invalid;
      end
    endcase
  end

  assign dec_val = (uop != uop_invalid);
  assign jump    = (uop == uop_jal) || (uop == uop_jalr);
  // No destination for invalid ops or stores
  assign waddr   = (wen && dec_val) ? inst[11:7] : '0;

  // ----------------------------------------------------------------------
  // Immediate generation
  // ----------------------------------------------------------------------

  always_comb begin
    case (imm_sel)
      imm_i:   imm = {{20{inst[31]}}, inst[31:20]};
      imm_s:   imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
      imm_j:   imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
      default: imm = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== logic/decode_pkg.sv ====
// Decode and issue package
// Shared ISA encodings, micro-op and immediate enums, and the fetch bundle
// used by the decode and issue stage of the in-order core

`default_nettype none

package decode_pkg;

  // ----------------------------------------------------------------------
  // Basic widths
  // ----------------------------------------------------------------------

  // Data word or program counter
  typedef logic [31:0] word_t;
  // Architectural register index
  typedef logic [4:0]  areg_t;
  // Tag for each instruction in flight
  typedef logic [7:0]  seq_t;

  // ----------------------------------------------------------------------
  // RV32 opcodes and function fields
  // ----------------------------------------------------------------------

  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;

  localparam logic [2:0] F3_ADD     = 3'b000;
  localparam logic [2:0] F3_WORD    = 3'b010;
  localparam logic [6:0] F7_BASE    = 7'b0000000;
  localparam logic [6:0] F7_MULDIV  = 7'b0000001;

  // ----------------------------------------------------------------------
  // Enums
  // ----------------------------------------------------------------------

  // Micro-ops sent to execute
  typedef enum logic [2:0] {
    uop_add,
    uop_mul,
    uop_addi,
    uop_lw,
    uop_sw,
    uop_jal,
    uop_jalr,
    uop_invalid
  } uop_e;

  // Immediate formats
  typedef enum logic [1:0] {
    imm_i,
    imm_s,
    imm_j,
    imm_none
  } imm_e;

  // Instruction as handed over by fetch
  typedef struct packed {
    word_t inst;
    word_t pc;
    seq_t  seq;
  } fetch_bundle_t;

endpackage

`default_nettype wire
